//--- verilog/core_bus_pkg.sv
/*
 * Shared widths, AXI IDs and codes, and memory-op types for the core bus side.
 * Every RTL file pulls these in with a wildcard import.
 */

package core_bus_pkg;

	// bus geometry
	localparam int addr_w  = 64;
	localparam int data_w  = 64;
	localparam int instr_w = 32;
	localparam int id_w    = 4;
	localparam int strb_w  = data_w / 8;

	// fetch addresses are offset by this before they reach the bus
	localparam logic [addr_w-1:0] base_pc = 64'h0;

	// one fixed ID per master, read data is routed back on these
	localparam logic [id_w-1:0] id_if  = 4'd1;
	localparam logic [id_w-1:0] id_lsu = 4'd2;

	// AXI codes, single-beat doubleword transfers only
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [7:0] len_single  = 8'd0;
	localparam logic [2:0] size_double = 3'b011;
	localparam logic [1:0] burst_incr  = 2'b01;

	typedef enum logic {
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

	// access size of a load or store
	typedef enum logic [1:0] {
		SZ_B = 2'd0,
		SZ_H = 2'd1,
		SZ_W = 2'd2,
		SZ_D = 2'd3
	} mem_size_e;

	// shared by both masters
	// ST_ADDR is the request phase, ST_DATA waits for r or b
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_DATA
	} bus_state_e;

endpackage

//--- verilog/axi_rd_if.sv
/*
 * One AXI read address and read data channel pair.
 * The master modport sits on a requester, the slave modport on the arbiter.
 */

`timescale 1ns/1ps

interface axi_rd_if
	import core_bus_pkg::*;
();

	// address read
	logic              arvalid;
	logic              arready;
	logic [addr_w-1:0] araddr;
	logic [id_w-1:0]   arid;

	// data read
	logic              rvalid;
	logic              rready;
	logic [data_w-1:0] rdata;
	logic [id_w-1:0]   rid;
	logic [1:0]        rresp;
	logic              rlast;

	modport master (
		output arvalid, araddr, arid, rready,
		input  arready, rvalid, rdata, rid, rresp, rlast
	);

	modport slave (
		input  arvalid, araddr, arid, rready,
		output arready, rvalid, rdata, rid, rresp, rlast
	);

endinterface

//--- verilog/if_axi_master.sv
/*
 * Instruction fetch master. A fetch strobe becomes one aligned single-beat
 * AXI read, and the 32-bit half picked by pc bit 2 comes back with fetch_done.
 */

`timescale 1ns/1ps

module if_axi_master
	import core_bus_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,

	// core side
	input  logic                fetch_req,
	input  logic [addr_w-1:0]   fetch_pc,
	output logic                fetch_done,
	output logic [instr_w-1:0]  fetch_instr,

	// bus side
	axi_rd_if.master            bus
);

	bus_state_e        state;
	logic              done_q;
	logic [addr_w-1:0] araddr_q;
	logic              sel_hi;
	logic [instr_w-1:0] instr_q;
	logic              start;
	logic              beat_in;

	assign start   = fetch_req && (state == ST_IDLE);
	assign beat_in = bus.rvalid && bus.rready && bus.rlast;

	// control state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ST_IDLE;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (fetch_req)
						state <= ST_ADDR;
				end
				ST_ADDR: begin
					if (bus.arready)
						state <= ST_DATA;
				end
				ST_DATA: begin
					if (beat_in) begin
						done_q <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request and returned word
	always_ff @(posedge clk) begin
		if (start) begin
			araddr_q <= {fetch_pc[addr_w-1:3], 3'b000} + base_pc;
			sel_hi   <= fetch_pc[2];
		end
		if (state == ST_DATA && beat_in)
			instr_q <= sel_hi ? bus.rdata[63:32] : bus.rdata[31:0];
	end

	assign bus.arvalid = (state == ST_ADDR);
	assign bus.araddr  = araddr_q;
	assign bus.arid    = id_if;
	assign bus.rready  = (state == ST_DATA);

	assign fetch_done  = done_q;
	assign fetch_instr = instr_q;

	// one fetch at a time
	assert property (@(posedge clk) disable iff (!rst_n)
		fetch_req |-> state == ST_IDLE);

	// address holds while the slave stalls
	assert property (@(posedge clk) disable iff (!rst_n)
		bus.arvalid && !bus.arready |=> $stable(bus.araddr));

endmodule

//--- verilog/lsu_axi_master.sv
/*
 * Load/store master. Loads read one beat and return the zero-extended lane,
 * stores drive aw and w together with lane-shifted data and byte strobes.
 * A non-okay response sets lsu_err alongside lsu_done.
 */

`timescale 1ns/1ps

module lsu_axi_master
	import core_bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,

	// core side
	input  logic              lsu_req,
	input  mem_op_e           lsu_op,
	input  mem_size_e         lsu_size,
	input  logic [addr_w-1:0] lsu_addr,
	input  logic [data_w-1:0] lsu_wdata,
	output logic              lsu_done,
	output logic [data_w-1:0] lsu_rdata,
	output logic              lsu_err,

	// read channels
	axi_rd_if.master          rd,

	// write channels
	output logic              awvalid,
	input  logic              awready,
	output logic [addr_w-1:0] awaddr,
	output logic [id_w-1:0]   awid,
	output logic              wvalid,
	input  logic              wready,
	output logic [data_w-1:0] wdata,
	output logic [strb_w-1:0] wstrb,
	output logic              wlast,
	input  logic              bvalid,
	output logic              bready,
	input  logic [id_w-1:0]   bid,
	input  logic [1:0]        bresp
);

	bus_state_e        state;
	logic              awvalid_q;
	logic              wvalid_q;
	logic              done_q;
	mem_op_e           op_q;
	mem_size_e         size_q;
	logic [2:0]        off_q;
	logic [addr_w-1:0] addr_q;
	logic [data_w-1:0] wdata_q;
	logic [strb_w-1:0] wstrb_q;
	logic [data_w-1:0] rdata_q;
	logic              err_q;
	logic [strb_w-1:0] strb_base;
	logic [data_w-1:0] load_shift;
	logic [data_w-1:0] load_val;
	logic              start;
	logic              load_fin;
	logic              store_fin;
	logic              aw_ok;
	logic              w_ok;

	assign start     = lsu_req && (state == ST_IDLE);
	assign load_fin  = (op_q == MEM_LOAD) && rd.rvalid && rd.rready && rd.rlast;
	assign store_fin = (op_q == MEM_STORE) && bvalid && bready;
	// each write channel finishes on its own ready
	assign aw_ok     = !awvalid_q || awready;
	assign w_ok      = !wvalid_q || wready;

	// strobe pattern before the offset shift
	always_comb begin
		case (lsu_size)
			SZ_B:    strb_base = 8'h01;
			SZ_H:    strb_base = 8'h03;
			SZ_W:    strb_base = 8'h0f;
			default: strb_base = 8'hff;
		endcase
	end

	// bring the addressed lane down and clear the bytes above the size
	always_comb begin
		load_shift = rd.rdata >> {off_q, 3'b000};
		case (size_q)
			SZ_B:    load_val = {{(data_w-8){1'b0}}, load_shift[7:0]};
			SZ_H:    load_val = {{(data_w-16){1'b0}}, load_shift[15:0]};
			SZ_W:    load_val = {{(data_w-32){1'b0}}, load_shift[31:0]};
			default: load_val = load_shift;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= ST_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (lsu_req) begin
						state     <= ST_ADDR;
						awvalid_q <= (lsu_op == MEM_STORE);
						wvalid_q  <= (lsu_op == MEM_STORE);
					end
				end
				ST_ADDR: begin
					if (op_q == MEM_LOAD) begin
						if (rd.arready)
							state <= ST_DATA;
					end else begin
						if (awready)
							awvalid_q <= 1'b0;
						if (wready)
							wvalid_q <= 1'b0;
						if (aw_ok && w_ok)
							state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (load_fin || store_fin) begin
						done_q <= 1'b1;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request payload and result
	always_ff @(posedge clk) begin
		if (start) begin
			op_q    <= lsu_op;
			size_q  <= lsu_size;
			off_q   <= lsu_addr[2:0];
			addr_q  <= {lsu_addr[addr_w-1:3], 3'b000};
			wdata_q <= lsu_wdata << {lsu_addr[2:0], 3'b000};
			wstrb_q <= strb_base << lsu_addr[2:0];
		end
		if (state == ST_DATA && load_fin) begin
			rdata_q <= load_val;
			err_q   <= (rd.rresp != resp_okay);
		end
		if (state == ST_DATA && store_fin) begin
			rdata_q <= '0;
			err_q   <= (bresp != resp_okay);
		end
	end

	assign rd.arvalid = (state == ST_ADDR) && (op_q == MEM_LOAD);
	assign rd.araddr  = addr_q;
	assign rd.arid    = id_lsu;
	assign rd.rready  = (state == ST_DATA) && (op_q == MEM_LOAD);

	assign awvalid = awvalid_q;
	assign awaddr  = addr_q;
	assign awid    = id_lsu;
	assign wvalid  = wvalid_q;
	assign wdata   = wdata_q;
	assign wstrb   = wstrb_q;
	assign wlast   = wvalid_q;
	assign bready  = (state == ST_DATA) && (op_q == MEM_STORE);

	assign lsu_done  = done_q;
	assign lsu_rdata = rdata_q;
	assign lsu_err   = err_q;

	assert property (@(posedge clk) disable iff (!rst_n)
		lsu_req |-> state == ST_IDLE);

	assert property (@(posedge clk) disable iff (!rst_n)
		wvalid |-> wlast);

	// the slave must echo our write ID
	assert property (@(posedge clk) disable iff (!rst_n)
		bvalid |-> bid == id_lsu);

endmodule

//--- verilog/axi_rd_arbiter.sv
/*
 * Read arbiter for the fetch and load/store masters. The address channel is
 * a combinational round-robin mux with the grant locked until arready, and
 * read data is steered back to its master by rid.
 */

`timescale 1ns/1ps

module axi_rd_arbiter
	import core_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	axi_rd_if.slave  if_side,
	axi_rd_if.slave  lsu_side,
	axi_rd_if.master mem
);

	// grant encoding is 0 for fetch, 1 for load/store
	logic sel;
	logic grant_q;
	logic lock_q;
	logic last_q;
	logic to_if;
	logic to_lsu;

	always_comb begin
		if (lock_q)
			sel = grant_q;
		else if (if_side.arvalid && lsu_side.arvalid)
			sel = ~last_q;
		else
			sel = lsu_side.arvalid;
	end

	// remember the stalled grant and who went last
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant_q <= 1'b0;
			lock_q  <= 1'b0;
			last_q  <= 1'b1;
		end else begin
			if (mem.arvalid) begin
				grant_q <= sel;
				lock_q  <= !mem.arready;
			end else begin
				lock_q <= 1'b0;
			end
			if (mem.arvalid && mem.arready)
				last_q <= sel;
		end
	end

	// address mux
	assign mem.arvalid = sel ? lsu_side.arvalid : if_side.arvalid;
	assign mem.araddr  = sel ? lsu_side.araddr : if_side.araddr;
	assign mem.arid    = sel ? lsu_side.arid : if_side.arid;

	assign if_side.arready  = mem.arready && !sel;
	assign lsu_side.arready = mem.arready && sel;

	// read data routing
	assign to_if  = (mem.rid == id_if);
	assign to_lsu = (mem.rid == id_lsu);

	assign if_side.rvalid  = mem.rvalid && to_if;
	assign lsu_side.rvalid = mem.rvalid && to_lsu;

	assign if_side.rdata  = mem.rdata;
	assign if_side.rid    = mem.rid;
	assign if_side.rresp  = mem.rresp;
	assign if_side.rlast  = mem.rlast;
	assign lsu_side.rdata = mem.rdata;
	assign lsu_side.rid   = mem.rid;
	assign lsu_side.rresp = mem.rresp;
	assign lsu_side.rlast = mem.rlast;

	always_comb begin
		if (to_lsu)
			mem.rready = lsu_side.rready;
		else if (to_if)
			mem.rready = if_side.rready;
		else
			mem.rready = 1'b0;
	end

	// no switching under a stalled address
	assert property (@(posedge clk) disable iff (!rst_n)
		mem.arvalid && !mem.arready |=> sel == $past(sel));

	assert property (@(posedge clk) disable iff (!rst_n)
		mem.rvalid |-> (mem.rid == id_if) || (mem.rid == id_lsu));

endmodule

//--- verilog/core_bus_top.sv
/*
 * Bus side of the core. Fetch and load/store masters share one AXI4 master
 * port for reads through the arbiter, and stores go straight out.
 */

`timescale 1ns/1ps

module core_bus_top
	import core_bus_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,

	// fetch
	input  logic               fetch_req,
	input  logic [addr_w-1:0]  fetch_pc,
	output logic               fetch_done,
	output logic [instr_w-1:0] fetch_instr,

	// load/store
	input  logic               lsu_req,
	input  mem_op_e            lsu_op,
	input  mem_size_e          lsu_size,
	input  logic [addr_w-1:0]  lsu_addr,
	input  logic [data_w-1:0]  lsu_wdata,
	output logic               lsu_done,
	output logic [data_w-1:0]  lsu_rdata,
	output logic               lsu_err,

	// AXI read
	output logic               m_arvalid,
	input  logic               m_arready,
	output logic [addr_w-1:0]  m_araddr,
	output logic [id_w-1:0]    m_arid,
	output logic [7:0]         m_arlen,
	output logic [2:0]         m_arsize,
	output logic [1:0]         m_arburst,
	input  logic               m_rvalid,
	output logic               m_rready,
	input  logic [data_w-1:0]  m_rdata,
	input  logic [id_w-1:0]    m_rid,
	input  logic [1:0]         m_rresp,
	input  logic               m_rlast,

	// AXI write
	output logic               m_awvalid,
	input  logic               m_awready,
	output logic [addr_w-1:0]  m_awaddr,
	output logic [id_w-1:0]    m_awid,
	output logic [7:0]         m_awlen,
	output logic [2:0]         m_awsize,
	output logic [1:0]         m_awburst,
	output logic               m_wvalid,
	input  logic               m_wready,
	output logic [data_w-1:0]  m_wdata,
	output logic [strb_w-1:0]  m_wstrb,
	output logic               m_wlast,
	input  logic               m_bvalid,
	output logic               m_bready,
	input  logic [id_w-1:0]    m_bid,
	input  logic [1:0]         m_bresp
);

	axi_rd_if if_bus ();
	axi_rd_if lsu_bus ();
	axi_rd_if mem_bus ();

	if_axi_master if_u (
		.clk(clk), .rst_n(rst_n),
		.fetch_req(fetch_req), .fetch_pc(fetch_pc),
		.fetch_done(fetch_done), .fetch_instr(fetch_instr),
		.bus(if_bus.master)
	);

	lsu_axi_master lsu_u (
		.clk(clk), .rst_n(rst_n),
		.lsu_req(lsu_req), .lsu_op(lsu_op), .lsu_size(lsu_size),
		.lsu_addr(lsu_addr), .lsu_wdata(lsu_wdata),
		.lsu_done(lsu_done), .lsu_rdata(lsu_rdata), .lsu_err(lsu_err),
		.rd(lsu_bus.master),
		.awvalid(m_awvalid), .awready(m_awready), .awaddr(m_awaddr), .awid(m_awid),
		.wvalid(m_wvalid), .wready(m_wready), .wdata(m_wdata), .wstrb(m_wstrb),
		.wlast(m_wlast), .bvalid(m_bvalid), .bready(m_bready), .bid(m_bid),
		.bresp(m_bresp)
	);

	axi_rd_arbiter arb_u (
		.clk(clk), .rst_n(rst_n),
		.if_side(if_bus.slave), .lsu_side(lsu_bus.slave), .mem(mem_bus.master)
	);

	// break the shared read port out to pins
	assign m_arvalid         = mem_bus.arvalid;
	assign m_araddr          = mem_bus.araddr;
	assign m_arid            = mem_bus.arid;
	assign m_rready          = mem_bus.rready;
	assign mem_bus.arready   = m_arready;
	assign mem_bus.rvalid    = m_rvalid;
	assign mem_bus.rdata     = m_rdata;
	assign mem_bus.rid       = m_rid;
	assign mem_bus.rresp     = m_rresp;
	assign mem_bus.rlast     = m_rlast;

	// single-beat doubleword transfers
	assign m_arlen   = len_single;
	assign m_arsize  = size_double;
	assign m_arburst = burst_incr;
	assign m_awlen   = len_single;
	assign m_awsize  = size_double;
	assign m_awburst = burst_incr;

endmodule

//--- testbench/bus_checker.sv
/*
 * Watches the fetch and load/store done strobes and compares them with the
 * values the testbench expects for the current test. One line per result.
 * Also watches the fixed AXI length, size, burst and wlast pins.
 */

`timescale 1ns/1ps

module bus_checker
	import core_bus_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               fetch_done,
	input  logic [instr_w-1:0] fetch_instr,
	input  logic               lsu_done,
	input  logic [data_w-1:0]  lsu_rdata,
	input  logic               lsu_err,
	input  logic               m_arvalid,
	input  logic [7:0]         m_arlen,
	input  logic [2:0]         m_arsize,
	input  logic [1:0]         m_arburst,
	input  logic               m_awvalid,
	input  logic [7:0]         m_awlen,
	input  logic [2:0]         m_awsize,
	input  logic [1:0]         m_awburst,
	input  logic               m_wvalid,
	input  logic               m_wlast,
	input  int                 test_id,
	input  logic               want_fetch,
	input  logic               want_lsu,
	input  logic [instr_w-1:0] exp_instr,
	input  logic [data_w-1:0]  exp_rdata,
	input  logic               exp_err,
	output int                 n_checks,
	output int                 n_errors
);

	int checks = 0;
	int errors = 0;

	assign n_checks = checks;
	assign n_errors = errors;

	// done is high for a whole cycle, so the falling edge sees it once
	always @(negedge clk) begin
		if (rst_n && fetch_done) begin
			checks++;
			if (!want_fetch) begin
				errors++;
				$display("test %0d: fetch_done pulsed with no fetch outstanding", test_id);
			end else if (fetch_instr !== exp_instr) begin
				errors++;
				$display("Mismatch at %0t: test %0d fetch_instr %h, expected %h",
					$time, test_id, fetch_instr, exp_instr);
			end else begin
				$display("test %0d: fetch ok, instr %h", test_id, fetch_instr);
			end
		end
		if (rst_n && lsu_done) begin
			checks++;
			if (!want_lsu) begin
				errors++;
				$display("test %0d: lsu_done pulsed with no load or store outstanding",
					test_id);
			end else if (lsu_rdata !== exp_rdata || lsu_err !== exp_err) begin
				errors++;
				$display("Mismatch at %0t: test %0d lsu_rdata %h err %b, expected %h err %b",
					$time, test_id, lsu_rdata, lsu_err, exp_rdata, exp_err);
			end else begin
				$display("test %0d: lsu ok, data %h err %b", test_id, lsu_rdata, lsu_err);
			end
		end

		// every request is one 8-byte incrementing beat
		if (rst_n && m_arvalid &&
				(m_arlen !== 8'd0 || m_arsize !== 3'd3 || m_arburst !== 2'b01)) begin
			errors++;
			$display("Mismatch at %0t: ar len %h size %h burst %h, expected 00 3 1",
				$time, m_arlen, m_arsize, m_arburst);
		end
		if (rst_n && m_awvalid &&
				(m_awlen !== 8'd0 || m_awsize !== 3'd3 || m_awburst !== 2'b01)) begin
			errors++;
			$display("Mismatch at %0t: aw len %h size %h burst %h, expected 00 3 1",
				$time, m_awlen, m_awsize, m_awburst);
		end
		if (rst_n && m_wvalid && m_wlast !== 1'b1) begin
			errors++;
			$display("Mismatch at %0t: wlast %b on a single-beat write, expected 1",
				$time, m_wlast);
		end
	end

endmodule

//--- testbench/tb_core_bus_top.sv
/*
 * Testbench for the core bus top level. An AXI memory model with random
 * ready and valid delays answers both masters, and a table of fetches, loads
 * and stores runs in a loop while bus_checker compares each done strobe.
 */

`timescale 1ns/1ps

module tb_core_bus_top
	import core_bus_pkg::*;
();

	localparam int P_FETCH = 0;
	localparam int P_LSU   = 1;
	localparam int P_BOTH  = 2;

	localparam logic [63:0] fill_pat    = 64'h0123_4567_89ab_cdef;
	localparam logic [63:0] err_base    = 64'h1000;
	localparam logic [1:0]  resp_slverr = 2'b10;

	typedef struct packed {
		logic [1:0]  port;
		mem_op_e     op;
		mem_size_e   size;
		logic [63:0] addr;
		logic [63:0] pc;
		logic [63:0] wdata;
		logic [63:0] exp_data;
		logic        exp_err;
		logic [31:0] exp_instr;
	} entry_t;

	logic clk = 1'b0;
	logic rst_n;

	// core side
	logic               fetch_req;
	logic [addr_w-1:0]  fetch_pc;
	logic               fetch_done;
	logic [instr_w-1:0] fetch_instr;
	logic               lsu_req;
	mem_op_e            lsu_op;
	mem_size_e          lsu_size;
	logic [addr_w-1:0]  lsu_addr;
	logic [data_w-1:0]  lsu_wdata;
	logic               lsu_done;
	logic [data_w-1:0]  lsu_rdata;
	logic               lsu_err;

	// AXI side, slave outputs start idle
	logic               m_arvalid;
	logic               m_arready = 1'b0;
	logic [addr_w-1:0]  m_araddr;
	logic [id_w-1:0]    m_arid;
	logic [7:0]         m_arlen;
	logic [2:0]         m_arsize;
	logic [1:0]         m_arburst;
	logic               m_rvalid = 1'b0;
	logic               m_rready;
	logic [data_w-1:0]  m_rdata = '0;
	logic [id_w-1:0]    m_rid = '0;
	logic [1:0]         m_rresp = 2'b00;
	logic               m_rlast = 1'b0;
	logic               m_awvalid;
	logic               m_awready = 1'b0;
	logic [addr_w-1:0]  m_awaddr;
	logic [id_w-1:0]    m_awid;
	logic [7:0]         m_awlen;
	logic [2:0]         m_awsize;
	logic [1:0]         m_awburst;
	logic               m_wvalid;
	logic               m_wready = 1'b0;
	logic [data_w-1:0]  m_wdata;
	logic [strb_w-1:0]  m_wstrb;
	logic               m_wlast;
	logic               m_bvalid = 1'b0;
	logic               m_bready;
	logic [id_w-1:0]    m_bid = '0;
	logic [1:0]         m_bresp = 2'b00;

	// expected values handed to the checker
	int                 test_id;
	logic               want_fetch;
	logic               want_lsu;
	logic [instr_w-1:0] exp_instr;
	logic [data_w-1:0]  exp_rdata;
	logic               exp_err;
	int                 n_checks;
	int                 n_errors;
	logic               got_fetch;
	logic               got_lsu;

	entry_t      tbl[$];
	logic [63:0] shadow [logic [63:0]];
	logic [63:0] mem [logic [63:0]];

	// accepted requests, consumed by index from the negedge side
	logic [63:0]     rd_addr_q[$];
	logic [id_w-1:0] rd_id_q[$];
	logic [63:0]     aw_addr_q[$];
	logic [id_w-1:0] aw_id_q[$];
	logic [63:0]     w_data_q[$];
	logic [7:0]      w_strb_q[$];
	int r_hs = 0;
	int b_hs = 0;

	logic [31:0] rng = 32'h816c;
	int ar_wait = 0;
	int r_wait = 0;
	int aw_wait = 0;
	int w_wait = 0;
	int b_wait = 0;
	int rd_head = 0;
	int wr_head = 0;
	int r_taken = 0;
	int b_taken = 0;
	logic b_due = 1'b0;
	logic [1:0] b_resp_v = 2'b00;
	logic [id_w-1:0] b_id_v = '0;
	int cycles = 0;

	core_bus_top UUT (
		.clk(clk), .rst_n(rst_n),
		.fetch_req(fetch_req), .fetch_pc(fetch_pc),
		.fetch_done(fetch_done), .fetch_instr(fetch_instr),
		.lsu_req(lsu_req), .lsu_op(lsu_op), .lsu_size(lsu_size),
		.lsu_addr(lsu_addr), .lsu_wdata(lsu_wdata),
		.lsu_done(lsu_done), .lsu_rdata(lsu_rdata), .lsu_err(lsu_err),
		.m_arvalid(m_arvalid), .m_arready(m_arready), .m_araddr(m_araddr),
		.m_arid(m_arid), .m_arlen(m_arlen), .m_arsize(m_arsize), .m_arburst(m_arburst),
		.m_rvalid(m_rvalid), .m_rready(m_rready), .m_rdata(m_rdata), .m_rid(m_rid),
		.m_rresp(m_rresp), .m_rlast(m_rlast),
		.m_awvalid(m_awvalid), .m_awready(m_awready), .m_awaddr(m_awaddr),
		.m_awid(m_awid), .m_awlen(m_awlen), .m_awsize(m_awsize), .m_awburst(m_awburst),
		.m_wvalid(m_wvalid), .m_wready(m_wready), .m_wdata(m_wdata), .m_wstrb(m_wstrb),
		.m_wlast(m_wlast), .m_bvalid(m_bvalid), .m_bready(m_bready), .m_bid(m_bid),
		.m_bresp(m_bresp)
	);

	bus_checker checker_u (
		.clk(clk), .rst_n(rst_n),
		.fetch_done(fetch_done), .fetch_instr(fetch_instr),
		.lsu_done(lsu_done), .lsu_rdata(lsu_rdata), .lsu_err(lsu_err),
		.m_arvalid(m_arvalid), .m_arlen(m_arlen), .m_arsize(m_arsize),
		.m_arburst(m_arburst),
		.m_awvalid(m_awvalid), .m_awlen(m_awlen), .m_awsize(m_awsize),
		.m_awburst(m_awburst),
		.m_wvalid(m_wvalid), .m_wlast(m_wlast),
		.test_id(test_id), .want_fetch(want_fetch), .want_lsu(want_lsu),
		.exp_instr(exp_instr), .exp_rdata(exp_rdata), .exp_err(exp_err),
		.n_checks(n_checks), .n_errors(n_errors)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// wait of 0 to 3 cycles
	function automatic int next_delay();
		rng = xorshift(rng);
		return int'(rng[1:0]);
	endfunction

	// reset contents, doubleword index xor the fill pattern
	function automatic logic [63:0] fill_dw(input logic [63:0] idx);
		return idx ^ fill_pat;
	endfunction

	function automatic logic [63:0] shadow_dw(input logic [63:0] addr);
		if (addr < err_base && shadow.exists(addr >> 3))
			return shadow[addr >> 3];
		return fill_dw(addr >> 3);
	endfunction

	function automatic logic [63:0] read_dw(input logic [63:0] addr);
		if (addr < err_base && mem.exists(addr >> 3))
			return mem[addr >> 3];
		return fill_dw(addr >> 3);
	endfunction

	// zero-extended load value seen from the shadow
	function automatic logic [63:0] load_expect(input logic [63:0] addr, input mem_size_e size);
		logic [63:0] v;
		v = shadow_dw(addr) >> (int'(addr[2:0]) * 8);
		case (size)
			SZ_B:    return v & 64'hff;
			SZ_H:    return v & 64'hffff;
			SZ_W:    return v & 64'hffff_ffff;
			default: return v;
		endcase
	endfunction

	function automatic logic [31:0] fetch_expect(input logic [63:0] pc);
		logic [63:0] dw;
		dw = shadow_dw(pc);
		return pc[2] ? dw[63:32] : dw[31:0];
	endfunction

	task automatic shadow_store(input logic [63:0] addr, input mem_size_e size,
			input logic [63:0] wdata);
		logic [63:0] dw;
		int nb;
		int off;
		int i;
		nb = 1 << int'(size);
		off = int'(addr[2:0]);
		dw = shadow_dw(addr);
		for (i = 0; i < nb; i++)
			dw[8*(off+i) +: 8] = wdata[8*i +: 8];
		if (addr < err_base)
			shadow[addr >> 3] = dw;
	endtask

	task automatic add_fetch(input logic [63:0] pc);
		entry_t e;
		e = '0;
		e.port = 2'(P_FETCH);
		e.pc = pc;
		e.exp_instr = fetch_expect(pc);
		tbl.push_back(e);
	endtask

	task automatic add_lsu(input mem_op_e op, input mem_size_e size, input logic [63:0] addr,
			input logic [63:0] wdata);
		entry_t e;
		e = '0;
		e.port = 2'(P_LSU);
		e.op = op;
		e.size = size;
		e.addr = addr;
		e.wdata = wdata;
		e.exp_err = (addr >= err_base);
		if (op == MEM_LOAD)
			e.exp_data = load_expect(addr, size);
		else
			shadow_store(addr, size, wdata);
		tbl.push_back(e);
	endtask

	// fetch and load issued in the same cycle
	task automatic add_both(input logic [63:0] pc, input mem_size_e size,
			input logic [63:0] addr);
		entry_t e;
		e = '0;
		e.port = 2'(P_BOTH);
		e.op = MEM_LOAD;
		e.size = size;
		e.addr = addr;
		e.pc = pc;
		e.exp_err = (addr >= err_base);
		e.exp_data = load_expect(addr, size);
		e.exp_instr = fetch_expect(pc);
		tbl.push_back(e);
	endtask

	task automatic mem_write(input logic [63:0] addr, input logic [63:0] data,
			input logic [7:0] strb);
		logic [63:0] dw;
		int i;
		dw = read_dw(addr);
		for (i = 0; i < 8; i++)
			if (strb[i])
				dw[8*i +: 8] = data[8*i +: 8];
		if (addr < err_base)
			mem[addr >> 3] = dw;
	endtask

	// handshakes seen at the clock edge
	always @(posedge clk) begin
		if (m_arvalid && m_arready) begin
			rd_addr_q.push_back(m_araddr);
			rd_id_q.push_back(m_arid);
		end
		if (m_rvalid && m_rready)
			r_hs++;
		if (m_awvalid && m_awready) begin
			aw_addr_q.push_back(m_awaddr);
			aw_id_q.push_back(m_awid);
		end
		if (m_wvalid && m_wready) begin
			w_data_q.push_back(m_wdata);
			w_strb_q.push_back(m_wstrb);
		end
		if (m_bvalid && m_bready)
			b_hs++;
	end

	// memory slave outputs change on the falling edge
	always @(negedge clk) begin
		if (m_arvalid && !m_arready) begin
			if (ar_wait == 0)
				m_arready = 1'b1;
			else
				ar_wait--;
		end else begin
			m_arready = 1'b0;
			ar_wait = next_delay();
		end

		// read beats go out in order of acceptance
		if (m_rvalid && r_hs != r_taken) begin
			r_taken = r_hs;
			m_rvalid = 1'b0;
			rd_head++;
			r_wait = next_delay();
		end
		if (!m_rvalid && rd_head < rd_addr_q.size()) begin
			if (r_wait == 0) begin
				m_rvalid = 1'b1;
				m_rdata = read_dw(rd_addr_q[rd_head]);
				m_rid = rd_id_q[rd_head];
				m_rresp = (rd_addr_q[rd_head] >= err_base) ? resp_slverr : resp_okay;
				m_rlast = 1'b1;
			end else begin
				r_wait--;
			end
		end

		if (m_awvalid && !m_awready) begin
			if (aw_wait == 0)
				m_awready = 1'b1;
			else
				aw_wait--;
		end else begin
			m_awready = 1'b0;
			aw_wait = next_delay();
		end
		if (m_wvalid && !m_wready) begin
			if (w_wait == 0)
				m_wready = 1'b1;
			else
				w_wait--;
		end else begin
			m_wready = 1'b0;
			w_wait = next_delay();
		end

		// store lands once both address and data are in
		if (wr_head < aw_addr_q.size() && wr_head < w_data_q.size()) begin
			mem_write(aw_addr_q[wr_head], w_data_q[wr_head], w_strb_q[wr_head]);
			b_resp_v = (aw_addr_q[wr_head] >= err_base) ? resp_slverr : resp_okay;
			b_id_v = aw_id_q[wr_head];
			b_due = 1'b1;
			b_wait = next_delay();
			wr_head++;
		end
		if (m_bvalid && b_hs != b_taken) begin
			b_taken = b_hs;
			m_bvalid = 1'b0;
		end else if (b_due && !m_bvalid) begin
			if (b_wait == 0) begin
				m_bvalid = 1'b1;
				m_bid = b_id_v;
				m_bresp = b_resp_v;
				b_due = 1'b0;
			end else begin
				b_wait--;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 40 * tbl.size() + 100) begin
			$display("timeout: run stopped after %0d cycles with a transfer still open", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		fetch_req = 1'b0;
		fetch_pc = '0;
		lsu_req = 1'b0;
		lsu_op = MEM_LOAD;
		lsu_size = SZ_B;
		lsu_addr = '0;
		lsu_wdata = '0;
		test_id = 0;
		want_fetch = 1'b0;
		want_lsu = 1'b0;
		exp_instr = '0;
		exp_rdata = '0;
		exp_err = 1'b0;

		add_fetch(64'h100);
		add_fetch(64'h104);
		add_fetch(64'h238);
		add_fetch(64'h23c);
		add_lsu(MEM_LOAD, SZ_B, 64'h40, '0);
		add_lsu(MEM_LOAD, SZ_B, 64'h47, '0);
		add_lsu(MEM_LOAD, SZ_H, 64'h42, '0);
		add_lsu(MEM_LOAD, SZ_H, 64'h4e, '0);
		add_lsu(MEM_LOAD, SZ_W, 64'h44, '0);
		add_lsu(MEM_LOAD, SZ_W, 64'h80, '0);
		add_lsu(MEM_LOAD, SZ_D, 64'h88, '0);
		// upper bits of the store data must not reach memory
		add_lsu(MEM_STORE, SZ_B, 64'h201, 64'hffff_ffff_ffff_ff5a);
		add_lsu(MEM_LOAD, SZ_D, 64'h200, '0);
		add_lsu(MEM_STORE, SZ_H, 64'h20a, 64'h9999_9999_9999_beef);
		add_lsu(MEM_LOAD, SZ_D, 64'h208, '0);
		add_lsu(MEM_STORE, SZ_W, 64'h214, 64'h7777_7777_dead_beef);
		add_lsu(MEM_LOAD, SZ_D, 64'h210, '0);
		add_lsu(MEM_STORE, SZ_D, 64'h218, 64'h1122_3344_5566_7788);
		add_lsu(MEM_LOAD, SZ_D, 64'h218, '0);
		add_lsu(MEM_LOAD, SZ_H, 64'h21c, '0);
		add_both(64'h300, SZ_W, 64'h304);
		// a lone fetch hands the next tie to the load/store side
		add_fetch(64'h308);
		add_both(64'h204, SZ_D, 64'h218);
		add_both(64'h40c, SZ_H, 64'h812);
		add_lsu(MEM_LOAD, SZ_D, 64'h1000, '0);
		add_lsu(MEM_STORE, SZ_W, 64'h1008, 64'hcafe_f00d);
		add_lsu(MEM_LOAD, SZ_B, 64'hff8, '0);

		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		foreach (tbl[k]) begin
			@(negedge clk);
			test_id = k;
			want_fetch = (tbl[k].port != 2'(P_LSU));
			want_lsu = (tbl[k].port != 2'(P_FETCH));
			exp_instr = tbl[k].exp_instr;
			exp_rdata = tbl[k].exp_data;
			exp_err = tbl[k].exp_err;
			fetch_req = want_fetch;
			fetch_pc = tbl[k].pc;
			lsu_req = want_lsu;
			lsu_op = tbl[k].op;
			lsu_size = tbl[k].size;
			lsu_addr = tbl[k].addr;
			lsu_wdata = tbl[k].wdata;
			got_fetch = !want_fetch;
			got_lsu = !want_lsu;
			do begin
				@(negedge clk);
				fetch_req = 1'b0;
				lsu_req = 1'b0;
				if (fetch_done)
					got_fetch = 1'b1;
				if (lsu_done)
					got_lsu = 1'b1;
			end while (!(got_fetch && got_lsu));
		end

		@(negedge clk);
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- all.f
verilog/core_bus_pkg.sv
verilog/axi_rd_if.sv
verilog/if_axi_master.sv
verilog/lsu_axi_master.sv
verilog/axi_rd_arbiter.sv
verilog/core_bus_top.sv
testbench/bus_checker.sv
testbench/tb_core_bus_top.sv

//--- Makefile
TOP = tb_core_bus_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
